// File: source/ecc_pkg.sv
package ecc_pkg;

    // ALU operation selected per micro-op
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } alu_op_e;

    // Register bank slots, inputs first, then intermediates
    typedef enum logic [3:0] {
        SLOT_X1,
        SLOT_Y1,
        SLOT_X2,
        SLOT_Y2,
        SLOT_H,     // Also serves as Z3
        SLOT_R,
        SLOT_HH,
        SLOT_HHH,
        SLOT_V,
        SLOT_RR,
        SLOT_T,     // Scratch, reused across steps
        SLOT_V2,
        SLOT_X3,
        SLOT_Y3,
        SLOT_W
    } slot_e;

    // One step of the point-add program
    typedef struct packed {
        alu_op_e op;
        slot_e   src_a;
        slot_e   src_b;
        slot_e   dst;
    } micro_op_t;

    localparam int STEP_COUNT = 13;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_RELEASE,
        SEQ_DONE
    } seq_state_e;

endpackage

// File: source/ecc_cmd_if.sv
`timescale 1ns/1ps

// Command link from sequencer to register bank
// Four-phase req/ack, one micro-op in flight
interface ecc_cmd_if import ecc_pkg::*; ();

    logic      req;    // Raised with cmd stable
    logic      ack;    // Raised once the result is written back
    micro_op_t cmd;
    logic      load;   // Single-cycle input capture strobe

    modport producer (
        output req,
        output cmd,
        output load,
        input  ack
    );

    modport buffer (
        input  req,
        input  cmd,
        input  load,
        output ack
    );

endinterface

// File: source/ecc_arith_if.sv
`timescale 1ns/1ps

// Operand/result link between register bank and ALU
interface ecc_arith_if import ecc_pkg::*; #(
    parameter int WIDTH = 32
) ();

    logic             req;
    logic             ack;         // Result valid while high
    alu_op_e          op;
    logic [WIDTH-1:0] operand_a;
    logic [WIDTH-1:0] operand_b;
    logic [WIDTH-1:0] result;

    modport requester (
        output req,
        output op,
        output operand_a,
        output operand_b,
        input  ack,
        input  result
    );

    modport responder (
        input  req,
        input  op,
        input  operand_a,
        input  operand_b,
        output ack,
        output result
    );

endinterface

// File: source/ecc_sequencer.sv
`timescale 1ns/1ps

module ecc_sequencer import ecc_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    output logic        o_done,
    ecc_cmd_if.producer cmd
);

    localparam int STEP_BITS = $clog2(STEP_COUNT);

    seq_state_e           state_q;
    logic [STEP_BITS-1:0] step_q;
    logic                 start_d;
    logic                 start_edge;
    logic                 accept;

    // Point-add program, affine inputs with Z1 = Z2 = 1
    function automatic micro_op_t program_rom(input logic [STEP_BITS-1:0] step);
        case (step)
            4'd0:    program_rom = '{OP_SUB, SLOT_X2,  SLOT_X1,  SLOT_H};    // H = X2 - X1
            4'd1:    program_rom = '{OP_SUB, SLOT_Y2,  SLOT_Y1,  SLOT_R};    // R = Y2 - Y1
            4'd2:    program_rom = '{OP_MUL, SLOT_H,   SLOT_H,   SLOT_HH};
            4'd3:    program_rom = '{OP_MUL, SLOT_HH,  SLOT_H,   SLOT_HHH};
            4'd4:    program_rom = '{OP_MUL, SLOT_X1,  SLOT_HH,  SLOT_V};    // V = X1*H^2
            4'd5:    program_rom = '{OP_MUL, SLOT_R,   SLOT_R,   SLOT_RR};
            4'd6:    program_rom = '{OP_SUB, SLOT_RR,  SLOT_HHH, SLOT_T};
            4'd7:    program_rom = '{OP_ADD, SLOT_V,   SLOT_V,   SLOT_V2};
            4'd8:    program_rom = '{OP_SUB, SLOT_T,   SLOT_V2,  SLOT_X3};
            4'd9:    program_rom = '{OP_SUB, SLOT_V,   SLOT_X3,  SLOT_T};
            4'd10:   program_rom = '{OP_MUL, SLOT_R,   SLOT_T,   SLOT_T};    // T = R*(V - X3)
            4'd11:   program_rom = '{OP_MUL, SLOT_Y1,  SLOT_HHH, SLOT_W};
            4'd12:   program_rom = '{OP_SUB, SLOT_T,   SLOT_W,   SLOT_Y3};
            default: program_rom = '{OP_ADD, SLOT_W,   SLOT_W,   SLOT_W};    // Unreachable
        endcase
    endfunction

    // Rising edge of i_start, taken only between runs
    assign start_edge = i_start & ~start_d;
    assign accept     = start_edge && (state_q == SEQ_IDLE || state_q == SEQ_DONE);

    assign cmd.load = accept;            // Bank captures inputs on the accepting edge
    assign cmd.cmd  = program_rom(step_q);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_d <= 1'b0;
            state_q <= SEQ_IDLE;
            step_q  <= '0;
            cmd.req <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            start_d <= i_start;
            case (state_q)
                SEQ_IDLE, SEQ_DONE: begin
                    if (accept) begin
                        step_q  <= '0;
                        o_done  <= 1'b0;
                        state_q <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    cmd.req <= 1'b1;
                    state_q <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (cmd.ack) begin
                        cmd.req <= 1'b0;
                        state_q <= SEQ_RELEASE;
                    end
                end
                SEQ_RELEASE: begin
                    // Next step only after the bank has dropped ack
                    if (!cmd.ack) begin
                        if (step_q == STEP_BITS'(STEP_COUNT - 1)) begin
                            o_done  <= 1'b1;
                            state_q <= SEQ_DONE;
                        end else begin
                            step_q  <= step_q + 1'b1;
                            state_q <= SEQ_ISSUE;
                        end
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// File: source/ecc_reg_bank.sv
`timescale 1ns/1ps

module ecc_reg_bank import ecc_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [WIDTH-1:0] i_p,
    input  logic [WIDTH-1:0] i_x1,
    input  logic [WIDTH-1:0] i_y1,
    input  logic [WIDTH-1:0] i_x2,
    input  logic [WIDTH-1:0] i_y2,
    output logic [WIDTH-1:0] o_x3,
    output logic [WIDTH-1:0] o_y3,
    output logic [WIDTH-1:0] o_z3,
    output logic [WIDTH-1:0] o_mod,
    ecc_cmd_if.buffer        cmd,
    ecc_arith_if.requester   arith
);

    localparam int SLOT_NUM = int'(SLOT_W) + 1;

    logic [WIDTH-1:0] slot_q [SLOT_NUM];
    logic [WIDTH-1:0] mod_q;
    logic             issue;
    logic             retire;
    logic             release_ack;

    // New command, with both links idle
    assign issue = cmd.req && !cmd.ack && !arith.req && !arith.ack;

    // ALU result valid, write back and acknowledge the sequencer
    assign retire = arith.req && arith.ack;

    // Sequencer has released req and the ALU has finished its own handshake
    assign release_ack = cmd.ack && !cmd.req && !arith.ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            arith.req <= 1'b0;
            cmd.ack   <= 1'b0;
        end else begin
            if (issue) begin
                arith.req <= 1'b1;
            end else if (retire) begin
                arith.req <= 1'b0;
                cmd.ack   <= 1'b1;   // One cycle after the ALU ack
            end else if (release_ack) begin
                cmd.ack <= 1'b0;
            end
        end
    end

    // Slot storage and operand registers
    always_ff @(posedge i_clk) begin
        if (cmd.load) begin
            mod_q           <= i_p;
            slot_q[SLOT_X1] <= i_x1;
            slot_q[SLOT_Y1] <= i_y1;
            slot_q[SLOT_X2] <= i_x2;
            slot_q[SLOT_Y2] <= i_y2;
        end
        if (issue) begin
            arith.op        <= cmd.cmd.op;
            arith.operand_a <= slot_q[cmd.cmd.src_a];
            arith.operand_b <= slot_q[cmd.cmd.src_b];
        end
        // Operands already latched, so dst may equal a source
        if (retire) begin
            slot_q[cmd.cmd.dst] <= arith.result;
        end
    end

    assign o_x3  = slot_q[SLOT_X3];
    assign o_y3  = slot_q[SLOT_Y3];
    assign o_z3  = slot_q[SLOT_H];   // Z3 = H with Z1 = Z2 = 1
    assign o_mod = mod_q;

endmodule

// File: source/ecc_mod_alu.sv
`timescale 1ns/1ps

module ecc_mod_alu import ecc_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [WIDTH-1:0] i_mod,
    ecc_arith_if.responder   arith
);

    localparam int CNT_BITS = $clog2(WIDTH + 1);

    logic [WIDTH:0]      mod_ext;
    logic [WIDTH:0]      sum;
    logic [WIDTH:0]      diff;
    logic [WIDTH-1:0]    add_res;
    logic [WIDTH-1:0]    sub_res;
    logic                start;
    logic                last_bit;
    logic                mul_busy;
    logic [CNT_BITS-1:0] bit_cnt;
    logic [WIDTH-1:0]    mul_a;
    logic [WIDTH-1:0]    mul_b;      // Shifted left, MSB is the current bit
    logic [WIDTH-1:0]    acc_q;
    logic [WIDTH:0]      dbl;
    logic [WIDTH:0]      dbl_red;
    logic [WIDTH:0]      acc_add;
    logic [WIDTH-1:0]    acc_next;

    assign mod_ext = {1'b0, i_mod};

    // Add/sub in WIDTH+1 bits with a single correction by p
    assign sum     = {1'b0, arith.operand_a} + {1'b0, arith.operand_b};
    assign diff    = {1'b0, arith.operand_a} - {1'b0, arith.operand_b};
    assign add_res = (sum >= mod_ext) ? WIDTH'(sum - mod_ext) : sum[WIDTH-1:0];
    assign sub_res = diff[WIDTH] ? WIDTH'(diff + mod_ext) : diff[WIDTH-1:0];   // Borrow

    // One interleaved multiply step: acc = 2*acc + bit*a, reduced twice
    assign dbl      = {acc_q, 1'b0};
    assign dbl_red  = (dbl >= mod_ext) ? dbl - mod_ext : dbl;
    assign acc_add  = dbl_red + (mul_b[WIDTH-1] ? {1'b0, mul_a} : {(WIDTH + 1){1'b0}});
    assign acc_next = (acc_add >= mod_ext) ? WIDTH'(acc_add - mod_ext) : acc_add[WIDTH-1:0];

    assign start    = arith.req && !arith.ack && !mul_busy;
    assign last_bit = mul_busy && (bit_cnt == CNT_BITS'(1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            arith.ack <= 1'b0;
            mul_busy  <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            if (start && arith.op == OP_MUL) begin
                mul_busy <= 1'b1;
                bit_cnt  <= CNT_BITS'(WIDTH);
            end else if (start) begin
                arith.ack <= 1'b1;      // Add/sub answer next cycle
            end else if (mul_busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (last_bit) begin
                    mul_busy  <= 1'b0;
                    arith.ack <= 1'b1;  // WIDTH+1 cycles after req
                end
            end else if (arith.ack && !arith.req) begin
                arith.ack <= 1'b0;
            end
        end
    end

    // Datapath registers
    always_ff @(posedge i_clk) begin
        if (start) begin
            mul_a <= arith.operand_a;
            mul_b <= arith.operand_b;
            acc_q <= '0;
            if (arith.op != OP_MUL) begin
                arith.result <= (arith.op == OP_SUB) ? sub_res : add_res;
            end
        end else if (mul_busy) begin
            acc_q <= acc_next;
            mul_b <= mul_b << 1;
            if (last_bit) begin
                arith.result <= acc_next;
            end
        end
    end

endmodule

// File: source/ecc_point_add.sv
`timescale 1ns/1ps

module ecc_point_add #(
    parameter int WIDTH = 32
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic [WIDTH-1:0] i_p,
    input  logic [WIDTH-1:0] i_x1,
    input  logic [WIDTH-1:0] i_y1,
    input  logic [WIDTH-1:0] i_x2,
    input  logic [WIDTH-1:0] i_y2,
    output logic [WIDTH-1:0] o_x3,
    output logic [WIDTH-1:0] o_y3,
    output logic [WIDTH-1:0] o_z3,
    output logic             o_done
);

    logic [WIDTH-1:0] modulus;   // Captured p, bank to ALU

    ecc_cmd_if cmd_link ();

    ecc_arith_if #(
        .WIDTH(WIDTH)
    ) arith_link ();

    // Runs the micro-program, one command at a time
    ecc_sequencer sequencer_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .o_done  (o_done),
        .cmd     (cmd_link.producer)
    );

    ecc_reg_bank #(
        .WIDTH(WIDTH)
    ) reg_bank_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_p     (i_p),
        .i_x1    (i_x1),
        .i_y1    (i_y1),
        .i_x2    (i_x2),
        .i_y2    (i_y2),
        .o_x3    (o_x3),
        .o_y3    (o_y3),
        .o_z3    (o_z3),
        .o_mod   (modulus),
        .cmd     (cmd_link.buffer),
        .arith   (arith_link.requester)
    );

    // Shared add/sub/mul unit
    ecc_mod_alu #(
        .WIDTH(WIDTH)
    ) mod_alu_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_mod   (modulus),
        .arith   (arith_link.responder)
    );

endmodule

// File: dv/ecc_point_add_properties.sv
`timescale 1ns/1ps

module ecc_point_add_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_cmd_req,
    input logic i_cmd_ack,
    input logic i_alu_req,
    input logic i_alu_ack
);

    // Sequencer keeps req up until the bank answers
    property cmd_req_held;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_cmd_req && !i_cmd_ack |=> i_cmd_req;
    endproperty

    // ALU answers only a pending request
    property alu_ack_needs_req;
        @(posedge i_clk) disable iff (!i_rst_n)
            $rose(i_alu_ack) |-> i_alu_req;
    endproperty

    property req_low_in_reset;
        @(posedge i_clk) !i_rst_n |-> (!i_cmd_req && !i_alu_req);
    endproperty

    cmd_req_held_a: assert property (cmd_req_held)
        else $error("Command req dropped before the bank raised ack");

    alu_ack_needs_req_a: assert property (alu_ack_needs_req)
        else $error("ALU ack rose with no request pending");

    req_low_in_reset_a: assert property (req_low_in_reset)
        else $error("A req line is high while reset is asserted");

endmodule

// Attached to the bank, which sees both links
bind ecc_reg_bank ecc_point_add_properties props_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_cmd_req (cmd.req),
    .i_cmd_ack (cmd.ack),
    .i_alu_req (arith.req),
    .i_alu_ack (arith.ack)
);

// File: dv/tb_ecc_point_add.sv
`timescale 1ns/1ps

module tb_ecc_point_add import ecc_pkg::*; ();

    localparam int WIDTH        = 32;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_RUNS  = 200;
    localparam int TOTAL_RUNS   = RANDOM_RUNS + 8;   // Random, level, busy, corners, spare
    localparam int CYCLE_LIMIT  = TOTAL_RUNS * STEP_COUNT * (WIDTH + 8) + RESET_CYCLES;

    typedef logic [WIDTH-1:0]   word_t;
    typedef logic [2*WIDTH-1:0] wide_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_start;
    word_t       i_p;
    word_t       i_x1;
    word_t       i_y1;
    word_t       i_x2;
    word_t       i_y2;
    word_t       o_x3;
    word_t       o_y3;
    word_t       o_z3;
    logic        o_done;
    logic [31:0] lfsr_q;
    word_t       exp_x3;
    word_t       exp_y3;
    word_t       exp_z3;
    int          coord_errors;
    int          flag_errors;
    int          other_errors;
    int          cycle_count;
    int          done_rises = 0;

    ecc_point_add #(
        .WIDTH(WIDTH)
    ) ecc_point_add_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_p     (i_p),
        .i_x1    (i_x1),
        .i_y1    (i_y1),
        .i_x2    (i_x2),
        .i_y2    (i_y2),
        .o_x3    (o_x3),
        .o_y3    (o_y3),
        .o_z3    (o_z3),
        .o_done  (o_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge o_done) done_rises++;

    // Galois step, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output word_t w);
        for (int i = 0; i < WIDTH; i++) begin
            w      = {w[WIDTH-2:0], lfsr_q[0]};   // One LFSR step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic word_t mod_mul(input word_t a, input word_t b, input word_t p);
        wide_t prod;
        prod    = wide_t'(a) * wide_t'(b);
        mod_mul = word_t'(prod % wide_t'(p));
    endfunction

    function automatic word_t mod_sub(input word_t a, input word_t b, input word_t p);
        mod_sub = word_t'((wide_t'(a) + wide_t'(p) - wide_t'(b)) % wide_t'(p));
    endfunction

    // Affine inputs, Jacobian result
    task automatic point_add_model(input word_t p, x1, y1, x2, y2);
        word_t h;
        word_t r;
        word_t h2;
        word_t h3;
        word_t u;
        h      = mod_sub(x2, x1, p);
        r      = mod_sub(y2, y1, p);
        h2     = mod_mul(h, h, p);
        h3     = mod_mul(h2, h, p);
        u      = mod_mul(x1, h2, p);   // X1*H^2
        exp_x3 = mod_sub(mod_sub(mod_mul(r, r, p), h3, p), mod_mul(word_t'(2), u, p), p);
        exp_y3 = mod_sub(mod_mul(r, mod_sub(u, exp_x3, p), p), mod_mul(y1, h3, p), p);
        exp_z3 = h;
    endtask

    task automatic check_coord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            coord_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
            flag_errors++;
        end
    endtask

    // 1 ns past the next rising edge, for driving and sampling alike
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    // Odd p with the top bit set, coordinates reduced below p
    task automatic load_random();
        word_t w;
        random_word(w);
        i_p = w | {1'b1, {(WIDTH - 2){1'b0}}, 1'b1};
        random_word(w);
        i_x1 = w % i_p;
        random_word(w);
        i_y1 = w % i_p;
        random_word(w);
        i_x2 = w % i_p;
        random_word(w);
        i_y2 = w % i_p;
    endtask

    task automatic start_run(input string name, input logic hold);
        point_add_model(i_p, i_x1, i_y1, i_x2, i_y2);
        i_start = 1'b1;
        next_cycle();
        check_flag({name, " done after start"}, 1'b0, o_done);
        if (!hold) begin
            i_start = 1'b0;
        end
    endtask

    task automatic wait_done();
        while (!o_done) begin
            next_cycle();   // Watchdog bounds this
        end
    endtask

    task automatic check_results(input string name);
        check_coord({name, " x3"}, exp_x3, o_x3);
        check_coord({name, " y3"}, exp_y3, o_y3);
        check_coord({name, " z3"}, exp_z3, o_z3);
    endtask

    task automatic run_and_check(input string name);
        start_run(name, 1'b0);
        wait_done();
        check_results(name);
        next_cycle();
    endtask

    initial begin
        int rises;
        lfsr_q       = 32'd54027;
        coord_errors = 0;
        flag_errors  = 0;
        other_errors = 0;
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_p          = '0;
        i_x1         = '0;
        i_y1         = '0;
        i_x2         = '0;
        i_y2         = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_flag("reset done", 1'b0, o_done);
        next_cycle();
        check_flag("idle done", 1'b0, o_done);

        for (int n = 0; n < RANDOM_RUNS; n++) begin
            load_random();
            run_and_check("random");
        end

        // Start held high, no second edge
        load_random();
        rises = done_rises;
        start_run("level", 1'b1);
        wait_done();
        repeat (3 * (WIDTH + 8)) begin
            next_cycle();
            check_flag("level done held", 1'b1, o_done);
        end
        check_results("level");
        if (done_rises - rises != 1) begin
            $display("o_done rose %0d times with start held, expected once", done_rises - rises);
            other_errors++;
        end
        i_start = 1'b0;
        next_cycle();

        // New edge and new inputs while busy
        load_random();
        start_run("busy", 1'b0);
        repeat (WIDTH + 8) next_cycle();
        check_flag("busy mid-run done", 1'b0, o_done);
        load_random();
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
        wait_done();
        check_results("busy");
        next_cycle();

        load_random();
        i_x2 = i_x1;   // H = 0
        run_and_check("equal x");
        check_coord("equal x z3 zero", '0, o_z3);
        load_random();
        i_x1 = i_p - 1'b1;
        i_y1 = i_p - 1'b1;
        run_and_check("p-1 coords");
        load_random();
        i_x1 = '0;
        i_y2 = '0;
        run_and_check("zero coords");
        load_random();
        i_x1 = i_p - 1'b1;
        i_y1 = '0;
        i_x2 = '0;
        i_y2 = i_p - 1'b1;
        run_and_check("mixed extremes");

        $display("Errors: %0d coordinate, %0d flag, %0d other",
                 coord_errors, flag_errors, other_errors);
        if (coord_errors + flag_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb.f
source/ecc_pkg.sv
source/ecc_cmd_if.sv
source/ecc_arith_if.sv
source/ecc_sequencer.sv
source/ecc_reg_bank.sv
source/ecc_mod_alu.sv
source/ecc_point_add.sv
dv/ecc_point_add_properties.sv
dv/tb_ecc_point_add.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ecc_point_add
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= PASS: all tests

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
